// ==== verilog/mem_if_config.svh ====
`ifndef MEM_IF_CONFIG_SVH
`define MEM_IF_CONFIG_SVH

// **********************************************************************
// data path geometry
// **********************************************************************
`define MEM_IF_NUM_DATA        4   // lanes per bus word
`define MEM_IF_DATA_WIDTH      16  // bits per lane

// **********************************************************************
// buffering
// **********************************************************************
`define MEM_IF_BUF_ADDR_WIDTH  4   // 16 entries per buffer

// **********************************************************************
// command fields
// **********************************************************************
`define MEM_IF_COUNT_WIDTH     8   // words per command
`define MEM_IF_SHIFT_WIDTH     2   // lane rotate amount, log2 of lane count

`endif

// ==== verilog/mem_if_data_pkg.sv ====
`include "mem_if_config.svh"

package mem_if_data_pkg;

    // one lane of the PE bus
    typedef logic [`MEM_IF_DATA_WIDTH-1:0] lane_t;

    // full memory word, lane 0 sits in the low bits
    typedef lane_t [`MEM_IF_NUM_DATA-1:0] word_t;

    // Buffers, shifter and the PE write bus all carry word_t,
    // so a change of lane count or width only touches the config
    // header.

endpackage

// ==== verilog/mem_if_ctrl_pkg.sv ====
`include "mem_if_config.svh"

package mem_if_ctrl_pkg;

    typedef enum logic [1:0] {
        op_load    = 2'd0,   // buffer -> shifter -> PE array
        op_compute = 2'd1,   // start pulse, wait for eoc
        op_store   = 2'd2    // PE results -> write buffer
    } opcode_t;              // code 3 unused, finishes at once

    typedef enum logic [2:0] {
        st_idle     = 3'd0,
        st_load     = 3'd1,
        st_compute  = 3'd2,
        st_wait_eoc = 3'd3,
        st_store    = 3'd4,
        st_done     = 3'd5
    } ctrl_state_t;

    typedef logic [`MEM_IF_COUNT_WIDTH-1:0] count_t;  // words in a command
    typedef logic [`MEM_IF_SHIFT_WIDTH-1:0] shift_t;  // lane rotate amount

endpackage

// ==== verilog/stream_fifo.sv ====
`timescale 1ns/1ps
`include "mem_if_config.svh"

module stream_fifo
    import mem_if_data_pkg::*;
#(
    parameter int ADDR_WIDTH = `MEM_IF_BUF_ADDR_WIDTH
) (
    input  logic  ACLK,
    input  logic  reset,
    input  logic  push,
    input  logic  pop,
    input  word_t data_in,
    output word_t data_out,
    output logic  empty,
    output logic  full
);

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    word_t                 mem [DEPTH];
    logic [ADDR_WIDTH-1:0] wr_ptr;
    logic [ADDR_WIDTH-1:0] rd_ptr;
    logic [ADDR_WIDTH:0]   count;     // one extra bit to tell full from empty
    logic                  do_push;
    logic                  do_pop;

    assign do_push = push && !full;   // push on full is dropped
    assign do_pop  = pop && !empty;   // pop on empty is dropped

    assign empty = (count == '0);
    assign full  = (count == (ADDR_WIDTH+1)'(DEPTH));

    // head word falls through, no read latency
    assign data_out = mem[rd_ptr];

    always_ff @(posedge ACLK)
    begin
        if (do_push)
        begin
            mem[wr_ptr] <= data_in;
        end
    end

    always_ff @(posedge ACLK)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;   // idle or push and pop together
            endcase
        end
    end

endmodule

// ==== verilog/lane_shifter.sv ====
`timescale 1ns/1ps
`include "mem_if_config.svh"

module lane_shifter
    import mem_if_data_pkg::*;
    import mem_if_ctrl_pkg::*;
(
    input  logic   ACLK,
    input  logic   reset,
    input  logic   load,
    input  shift_t shift,
    input  word_t  data_in,
    output word_t  data_out,
    output logic   valid
);

    word_t rotated;

    // output lane i takes input lane (i + shift) mod lane count
    always_comb
    begin
        for (int i = 0; i < `MEM_IF_NUM_DATA; i++)
        begin
            rotated[i] = data_in[(i + int'(shift)) % `MEM_IF_NUM_DATA];
        end
    end

    always_ff @(posedge ACLK)
    begin
        if (load)
            data_out <= rotated;       // payload only, held between loads
    end

    always_ff @(posedge ACLK)
    begin
        if (reset)
            valid <= 1'b0;
        else
            valid <= load;             // follows load by one cycle
    end

endmodule

// ==== verilog/word_counter.sv ====
`timescale 1ns/1ps

module word_counter
    import mem_if_ctrl_pkg::*;
(
    input  logic   ACLK,
    input  logic   reset,
    input  logic   start,
    input  count_t count_in,
    input  logic   step,
    output logic   last
);

    count_t remaining;

    // Words still to move in the running command. The controller
    // only steps while a command is active, and finishes on the step
    // that consumes the final word, so the count never underflows in
    // normal use.
    always_ff @(posedge ACLK)
    begin
        if (reset)
            remaining <= '0;
        else if (start)
            remaining <= count_in;            // new command
        else if (step && remaining != '0)
            remaining <= remaining - 1'b1;
    end

    assign last = (remaining == count_t'(1));   // one word left

endmodule

// ==== verilog/if_control.sv ====
`timescale 1ns/1ps

module if_control
    import mem_if_ctrl_pkg::*;
(
    input  logic    ACLK,
    input  logic    reset,

    input  logic    cmd_valid,
    input  opcode_t cmd_op,
    input  count_t  cmd_count,
    input  shift_t  cmd_shift,

    input  logic    rd_empty,
    output logic    rd_pop,
    input  logic    wr_full,
    output logic    wr_push,

    input  logic    data_inout_wb,
    input  logic    eoc,

    output shift_t  shift,

    output logic    cnt_start,
    output count_t  cnt_count,
    output logic    cnt_step,
    input  logic    cnt_last,

    output logic    compute_start,
    output logic    data_io_dir,
    output logic    busy,
    output logic    done
);

    ctrl_state_t state;
    ctrl_state_t state_next;
    logic        accept;

    assign accept = cmd_valid && (state == st_idle);   // ignored while busy

    // counter follows the command directly
    assign cnt_start = accept;
    assign cnt_count = cmd_count;

    // **********************************************************************
    // buffer strobes, only when the buffer can take them
    // **********************************************************************
    assign rd_pop   = (state == st_load) && !rd_empty;
    assign wr_push  = (state == st_store) && data_inout_wb && !wr_full;
    assign cnt_step = rd_pop || wr_push;

    assign compute_start = (state == st_compute);   // single cycle state
    assign data_io_dir   = (state == st_store);
    assign busy          = (state != st_idle);
    assign done          = (state == st_done);

    always_comb
    begin
        state_next = state;
        case (state)
            st_idle:
                if (accept)
                begin
                    if (cmd_count == '0)
                        state_next = st_done;
                    else
                        case (cmd_op)
                            op_load:    state_next = st_load;
                            op_compute: state_next = st_compute;
                            op_store:   state_next = st_store;
                            default:    state_next = st_done;   // spare code
                        endcase
                end
            st_load:     if (rd_pop && cnt_last) state_next = st_done;
            st_compute:  state_next = st_wait_eoc;
            st_wait_eoc: if (eoc) state_next = st_done;
            st_store:    if (wr_push && cnt_last) state_next = st_done;
            default:     state_next = st_idle;   // st_done
        endcase
    end

    always_ff @(posedge ACLK)
    begin
        if (reset)
        begin
            state <= st_idle;
            shift <= '0;
        end
        else
        begin
            state <= state_next;
            if (accept)
                shift <= cmd_shift;   // held for the whole command
        end
    end

endmodule

// ==== verilog/mem_interface.sv ====
`timescale 1ns/1ps
`include "mem_if_config.svh"

module mem_interface
    import mem_if_data_pkg::*;
    import mem_if_ctrl_pkg::*;
(
    input  logic    ACLK,
    input  logic    reset,
    input  logic    cmd_valid,
    input  opcode_t cmd_op,
    input  count_t  cmd_count,
    input  shift_t  cmd_shift,
    input  logic    in_valid,
    input  word_t   in_data,
    output logic    in_full,
    input  logic    eoc,
    input  logic    data_inout_wb,
    input  word_t   rdata,
    input  logic    out_pop,
    output logic    out_empty,
    output word_t   out_data,
    output word_t   wdata,
    output logic    wdata_valid,
    output logic    compute_start,
    output logic    data_io_dir,
    output logic    busy,
    output logic    done
);

    word_t  rd_head;
    logic   rd_empty;
    logic   rd_pop;
    logic   wr_full;
    logic   wr_push;
    shift_t shift;
    logic   cnt_start;
    count_t cnt_count;
    logic   cnt_step;
    logic   cnt_last;

    // **********************************************************************
    // memory -> PE array
    // **********************************************************************
    stream_fifo #(.ADDR_WIDTH(`MEM_IF_BUF_ADDR_WIDTH)) u_read_buffer (
        .ACLK(ACLK), .reset(reset), .push(in_valid), .pop(rd_pop),
        .data_in(in_data), .data_out(rd_head), .empty(rd_empty), .full(in_full));

    lane_shifter u_lane_shifter (
        .ACLK(ACLK), .reset(reset), .load(rd_pop), .shift(shift),
        .data_in(rd_head), .data_out(wdata), .valid(wdata_valid));

    // **********************************************************************
    // PE array -> memory, drained from outside
    // **********************************************************************
    stream_fifo #(.ADDR_WIDTH(`MEM_IF_BUF_ADDR_WIDTH)) u_write_buffer (
        .ACLK(ACLK), .reset(reset), .push(wr_push), .pop(out_pop),
        .data_in(rdata), .data_out(out_data), .empty(out_empty), .full(wr_full));

    word_counter u_word_counter (
        .ACLK(ACLK), .reset(reset), .start(cnt_start), .count_in(cnt_count),
        .step(cnt_step), .last(cnt_last));

    if_control u_if_control (
        .ACLK(ACLK), .reset(reset), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
        .cmd_count(cmd_count), .cmd_shift(cmd_shift), .rd_empty(rd_empty),
        .rd_pop(rd_pop), .wr_full(wr_full), .wr_push(wr_push),
        .data_inout_wb(data_inout_wb), .eoc(eoc), .shift(shift),
        .cnt_start(cnt_start), .cnt_count(cnt_count), .cnt_step(cnt_step),
        .cnt_last(cnt_last), .compute_start(compute_start),
        .data_io_dir(data_io_dir), .busy(busy), .done(done));

endmodule

// ==== verification/tb_mem_interface.sv ====
`timescale 1ns/1ps
`include "mem_if_config.svh"

module tb_mem_interface
    import mem_if_data_pkg::*;
    import mem_if_ctrl_pkg::*;
();

    localparam int BUF_DEPTH   = 2 ** `MEM_IF_BUF_ADDR_WIDTH;
    localparam int CYCLE_LIMIT = 4000;   // sequence runs about 600 cycles

    logic    ACLK;
    logic    reset;
    logic    cmd_valid;
    opcode_t cmd_op;
    count_t  cmd_count;
    shift_t  cmd_shift;
    logic    in_valid;
    word_t   in_data;
    logic    in_full;
    logic    eoc;
    logic    data_inout_wb;
    word_t   rdata;
    logic    out_pop;
    logic    out_empty;
    word_t   out_data;
    word_t   wdata;
    logic    wdata_valid;
    logic    compute_start;
    logic    data_io_dir;
    logic    busy;
    logic    done;

    logic [31:0] lfsr = 32'h24aa_f956;
    word_t       rd_q[$];                // read buffer model
    word_t       wr_q[$];                // write buffer model
    shift_t      cur_shift;
    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          valid_cnt = 0;
    int          done_cnt = 0;
    int          start_cnt = 0;
    int          accepted = 0;
    int          drained = 0;
    int          v_base;
    int          d_base;
    int          c_base;

    mem_interface DUT (.*);

    initial
    begin
        ACLK = 1'b0;
        forever #2 ACLK = ~ACLK;
    end

    // **********************************************************************
    // stimulus helpers and reference model
    // **********************************************************************
    function automatic logic take_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 32'h8020_0003;    // taps 32, 22, 2, 1
        return b;
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int k = 0; k < n; k++)
            v = {v[62:0], take_bit()};
        return v;
    endfunction

    // output lane i is input lane (i + s) mod lane count
    function automatic word_t rotate_word(input word_t w, input shift_t s);
        logic [2*$bits(word_t)-1:0] pair;
        pair = {w, w} >> (int'(s) * `MEM_IF_DATA_WIDTH);
        return pair[$bits(word_t)-1:0];
    endfunction

    task automatic check(input logic [63:0] got, input logic [63:0] exp, input string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
        end
    endtask

    task automatic push_words(input int n);
        for (int k = 0; k < n; k++)
        begin
            @(negedge ACLK);
            in_valid = 1'b1;
            in_data  = take_bits(64);
        end
        @(negedge ACLK);
        in_valid = 1'b0;
    endtask

    task automatic issue_cmd(input opcode_t op, input count_t cnt, input shift_t sh);
        @(negedge ACLK);
        check(busy, 1'b0, "busy before command");
        v_base    = valid_cnt;
        d_base    = done_cnt;
        c_base    = start_cnt;
        cur_shift = sh;
        cmd_valid = 1'b1;
        cmd_op    = op;
        cmd_count = cnt;
        cmd_shift = sh;
        @(negedge ACLK);
        cmd_valid = 1'b0;
    endtask

    task automatic finish_cmd(input int exp_valid, input int exp_start);
        while (!done)
            @(negedge ACLK);
        @(negedge ACLK);                  // counts of the done cycle settle here
        check(busy, 1'b0, "busy after done");
        check(valid_cnt - v_base, exp_valid, "wdata_valid strobes in command");
        check(done_cnt - d_base, 1, "done pulses in command");
        check(start_cnt - c_base, exp_start, "compute_start pulses in command");
    endtask

    // **********************************************************************
    // response monitor, samples the values of the cycle that ends
    // **********************************************************************
    always @(posedge ACLK)
    begin : monitor
        logic wr_full_m;
        if (!reset)
        begin
            wr_full_m = (wr_q.size() == BUF_DEPTH);
            if (done)
                done_cnt++;
            if (compute_start)
                start_cnt++;
            if (wdata_valid)
            begin
                valid_cnt++;
                if (rd_q.size() == 0)
                begin
                    errors++;
                    $display("ERROR at %0t ns: wdata_valid with no buffered word", $time);
                end
                else
                    check(wdata, rotate_word(rd_q.pop_front(), cur_shift), "rotated wdata");
            end
            check(in_full, rd_q.size() == BUF_DEPTH, "in_full");
            if (in_valid && rd_q.size() < BUF_DEPTH)
                rd_q.push_back(in_data);      // push on full is dropped
            check(out_empty, wr_q.size() == 0, "out_empty");
            if (out_pop && wr_q.size() != 0)
            begin
                drained++;
                check(out_data, wr_q.pop_front(), "drained out_data");
            end
            if (data_io_dir && data_inout_wb && !wr_full_m)
            begin
                accepted++;
                wr_q.push_back(rdata);
            end
        end
    end

    always @(posedge ACLK)
    begin
        cycles++;
        if (cycles == CYCLE_LIMIT)
        begin
            $display("ERROR: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("TESTS FAILED");
            $finish;
        end
    end

    initial
    begin
        reset = 1'b1;
        cmd_valid = 1'b0;
        cmd_op = op_load;
        cmd_count = '0;
        cmd_shift = '0;
        in_valid = 1'b0;
        in_data = '0;
        eoc = 1'b0;
        data_inout_wb = 1'b0;
        rdata = '0;
        out_pop = 1'b0;
        cur_shift = '0;
        repeat (4) @(posedge ACLK);
        @(negedge ACLK);
        reset = 1'b0;

        check({busy, done, wdata_valid, compute_start, data_io_dir}, 5'b0, "outputs after reset");
        check({out_empty, in_full}, 2'b10, "buffer flags after reset");

        for (int s = 0; s < 4; s++)
        begin
            push_words(8);
            issue_cmd(op_load, 8, shift_t'(s));
            finish_cmd(8, 0);
        end

        push_words(3);                    // load starves after 3 words
        issue_cmd(op_load, 6, 2'd1);
        repeat (10)
        begin
            @(negedge ACLK);
            check(done, 1'b0, "done during starved load");
        end
        check(valid_cnt - v_base, 3, "strobes while starved");
        push_words(3);
        finish_cmd(6, 0);

        issue_cmd(op_compute, 1, 2'd0);
        repeat (20)
        begin
            check({busy, done}, 2'b10, "busy and done before eoc");
            @(negedge ACLK);
        end
        eoc = 1'b1;
        finish_cmd(0, 1);
        eoc = 1'b0;

        // **********************************************************************
        // store fills the write buffer before any drain
        // **********************************************************************
        issue_cmd(op_store, 20, 2'd0);
        while (wr_q.size() < BUF_DEPTH)
        begin
            check(data_io_dir, 1'b1, "data_io_dir during store");
            data_inout_wb = take_bit();
            rdata         = take_bits(64);
            @(negedge ACLK);
        end
        repeat (6)
        begin
            check({busy, data_io_dir}, 2'b11, "stalled store on full buffer");
            data_inout_wb = take_bit();
            rdata         = take_bits(64);
            @(negedge ACLK);
        end
        out_pop = 1'b1;
        while (!done)
        begin
            data_inout_wb = take_bit();
            rdata         = take_bits(64);
            @(negedge ACLK);
        end
        data_inout_wb = 1'b0;
        finish_cmd(0, 0);
        while (!out_empty)
            @(negedge ACLK);
        out_pop = 1'b0;
        check(accepted, 20, "words accepted by store");
        check(drained, 20, "words drained from write buffer");

        push_words(BUF_DEPTH + 4);        // last 4 pushes hit a full buffer
        check(in_full, 1'b1, "in_full after overfill");
        check(rd_q.size(), BUF_DEPTH, "words held after overfill");
        issue_cmd(op_load, BUF_DEPTH, 2'd3);
        finish_cmd(BUF_DEPTH, 0);
        check(rd_q.size(), 0, "words left after full load");
        check(in_full, 1'b0, "in_full after full load");

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== sim.f ====
+incdir+verilog
verilog/mem_if_data_pkg.sv
verilog/mem_if_ctrl_pkg.sv
verilog/stream_fifo.sv
verilog/lane_shifter.sv
verilog/word_counter.sv
verilog/if_control.sv
verilog/mem_interface.sv
verification/tb_mem_interface.sv

// ==== Makefile ====
TOP = tb_mem_interface

.PHONY: all compile run clean

all: run

compile:
	verilator --binary -Wno-fatal -j 0 --top-module $(TOP) -f sim.f -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then \
		echo "simulation failed"; exit 1; \
	fi
	@grep -q "TESTS PASSED" sim.log || (echo "no result in log"; exit 1)

clean:
	rm -rf obj_dir sim.log
